// ==== compile.f ====
+incdir+hw
hw/dphy_rx_pkg.sv
hw/dphy_lane_if.sv
hw/dphy_settle_ignore.sv
hw/dphy_byte_align.sv
hw/dphy_word_align.sv
hw/dphy_32b_map.sv
hw/dphy_rx_core.sv
verification/dphy_rx_props.sv
verification/dphy_rx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dphy_rx_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/dphy_rx_tb.sv ====
`timescale 1ns/1ps

`include "dphy_rx_defines.svh"

module dphy_rx_tb import dphy_rx_pkg::*; ();

  localparam int         lanes     = `DPHY_DATA_LANES;
  localparam int         num_tests = 8;
  localparam int         hs_zero   = 2;
  localparam int         seq_max   = 64;
  localparam lane_byte_t sync_byte = `DPHY_SYNC_BYTE;

  // Offsets and skews hold 4 bits per lane with lane 0 lowest
  typedef struct {
    logic [31:0] off;
    logic [31:0] skew;
    int          len;
    logic [7:0]  pseed;
    logic        flush;
  } test_t;

  test_t tests [num_tests];

  logic                    byte_clk_i = 1'b0;
  logic                    rst_n_i;
  logic                    enable_i;
  logic                    eop_i;
  logic [lanes-1:0]        lp_data_p_i;
  logic [lanes-1:0]        lp_data_n_i;
  logic [8*lanes-1:0]      raw_byte_i;
  logic [31:0]             data_o;
  logic                    valid_o;

  logic [1:0]  lane_lp  [lanes][seq_max];
  lane_byte_t  lane_raw [lanes][seq_max];
  lane_byte_t  payload  [64];
  logic [31:0] exp_q [$];
  logic [31:0] got_q [$];
  int          seq_len;
  integer      seed = 32'h38e1_ffd1;
  int          errors = 0;
  int          passed = 0;

  dphy_rx_core dphy_rx_core_i (
    .byte_clk_i  ( byte_clk_i  ),
    .rst_n_i     ( rst_n_i     ),
    .enable_i    ( enable_i    ),
    .eop_i       ( eop_i       ),
    .lp_data_p_i ( lp_data_p_i ),
    .lp_data_n_i ( lp_data_n_i ),
    .raw_byte_i  ( raw_byte_i  ),
    .data_o      ( data_o      ),
    .valid_o     ( valid_o     )
  );

  always #20 byte_clk_i = ~byte_clk_i;

  always @(negedge byte_clk_i)
  begin
    if (valid_o)
      got_q.push_back(data_o);
  end

  function automatic int test_cycles(input int t);
    return 6 + `DPHY_SETTLE_CYCLES + hs_zero + tests[t].len / lanes + 3
           + `DPHY_DESKEW_DEPTH + 8 + 1 + 4;
  endfunction

  // Per-lane LP levels and raw bytes with one entry per byte clock
  task automatic build_lane(input int l, input int t);
    int   off;
    int   n;
    int   pos;
    int   base;
    int   k;
    int   b;
    logic stream [seq_max*8];
    off = int'(tests[t].off[4*l +: 3]);
    n   = tests[t].len / lanes;
    for (k = 0; k < seq_max*8; k++)
      stream[k] = 1'b0;
    pos = 8*hs_zero + off;
    for (b = 0; b < 8; b++)
      stream[pos + b] = sync_byte[b];
    for (k = 0; k < n; k++)
      for (b = 0; b < 8; b++)
        stream[pos + 8 + 8*k + b] = payload[k*lanes + l][b];
    // LP11 stop followed by LP01 request
    for (k = 0; k < 5; k++)
    begin
      lane_lp[l][k]  = (k < 3) ? 2'b11 : 2'b01;
      lane_raw[l][k] = 8'h00;
    end
    // Settle bytes with one fake sync pattern among them
    for (k = 0; k <= `DPHY_SETTLE_CYCLES; k++)
    begin
      lane_lp[l][5+k]  = 2'b00;
      lane_raw[l][5+k] = (k == 1) ? sync_byte : 8'($random(seed));
    end
    base = 6 + `DPHY_SETTLE_CYCLES;
    // Lane returns to LP11 together with its last HS byte
    for (k = 0; k < hs_zero + n + 2; k++)
    begin
      lane_lp[l][base+k] = (k == hs_zero + n + 1) ? 2'b11 : 2'b00;
      for (b = 0; b < 8; b++)
        lane_raw[l][base+k][b] = stream[8*k + b];
    end
    seq_len = base + hs_zero + n + 3;
    lane_lp[l][seq_len-1]  = 2'b11;
    lane_raw[l][seq_len-1] = 8'h00;
  endtask

  task automatic drive_cycle(input int t, input int cyc);
    int idx;
    for (int l = 0; l < lanes; l++)
    begin
      idx = cyc - int'(tests[t].skew[4*l +: 4]);
      if (idx < 0 || idx >= seq_len)
      begin
        {lp_data_p_i[l], lp_data_n_i[l]} = 2'b11;
        raw_byte_i[8*l +: 8] = 8'h00;
      end
      else
      begin
        {lp_data_p_i[l], lp_data_n_i[l]} = lane_lp[l][idx];
        raw_byte_i[8*l +: 8] = lane_raw[l][idx];
      end
    end
  endtask

  task automatic run_test(input int t);
    int          len;
    int          k;
    int          b;
    int          fails;
    logic [31:0] w;
    len   = tests[t].len;
    fails = 0;
    got_q.delete();
    exp_q.delete();
    for (k = 0; k < len; k++)
      payload[k] = 8'($random(seed)) ^ tests[t].pseed;
    // Bytes fill each word from the low end and the tail is zero padded
    for (k = 0; k < len; k += 4)
    begin
      w = '0;
      for (b = 0; b < 4; b++)
        if (k + b < len)
          w[8*b +: 8] = payload[k + b];
      exp_q.push_back(w);
    end
    for (int l = 0; l < lanes; l++)
      build_lane(l, t);
    for (k = 0; k < seq_len + 16 + 8; k++)
    begin
      drive_cycle(t, k);
      @(posedge byte_clk_i);
      #2;
    end
    eop_i = 1'b1;
    @(posedge byte_clk_i);
    #2;
    eop_i = 1'b0;
    repeat (4) @(posedge byte_clk_i);
    #2;
    if (got_q.size() != exp_q.size())
    begin
      $display("Test %0d: expected %0d words but received %0d", t, exp_q.size(), got_q.size());
      fails++;
    end
    for (k = 0; k < exp_q.size() && k < got_q.size(); k++)
    begin
      if (got_q[k] !== exp_q[k])
      begin
        $display("FAIL %0t: test %0d word %0d is %h, expected %h",
                 $time, t, k, got_q[k], exp_q[k]);
        fails++;
      end
    end
    if (tests[t].flush && got_q.size() > 0 && (got_q[$] >> (8 * (len % 4))) != 0)
    begin
      $display("FAIL %0t: test %0d flush word %h is not zero padded", $time, t, got_q[$]);
      fails++;
    end
    if (fails == 0)
      passed++;
    errors += fails;
    $display("Test %0d: offsets %h skew %h length %0d: %s", t, tests[t].off, tests[t].skew,
             len, (fails == 0) ? "ok" : "FAILED");
  endtask

  initial
  begin
    tests[0] = '{32'h00, 32'h00, 8,  8'h00, 1'b0};
    tests[1] = '{32'h21, 32'h00, 8,  8'h5a, 1'b0};
    tests[2] = '{32'h43, 32'h00, 12, 8'h3c, 1'b0};
    tests[3] = '{32'h65, 32'h00, 8,  8'hff, 1'b0};
    tests[4] = '{32'h37, 32'h30, 8,  8'h81, 1'b0};
    tests[5] = '{32'h12, 32'h02, 6,  8'h00, 1'b1};
    tests[6] = '{32'h74, 32'h21, 10, 8'h17, 1'b1};
    tests[7] = '{32'h56, 32'h13, 16, 8'he4, 1'b0};
    rst_n_i     = 1'b0;
    enable_i    = 1'b0;
    eop_i       = 1'b0;
    lp_data_p_i = '1;
    lp_data_n_i = '1;
    raw_byte_i  = '0;
    repeat (2) @(posedge byte_clk_i);
    #2;
    rst_n_i  = 1'b1;
    enable_i = 1'b1;
    // Rows run back to back so each packet also checks realignment
    for (int t = 0; t < num_tests; t++)
      run_test(t);
    $display("Tests run %0d, passed %0d, errors %0d", num_tests, passed, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  initial
  begin
    int total;
    #1;
    total = 50;
    for (int t = 0; t < num_tests; t++)
      total += test_cycles(t) + 24;
    #(total * 40);
    $display("Timeout: run did not finish within %0d byte clocks", total);
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== verification/dphy_rx_props.sv ====
`timescale 1ns/1ps

`include "dphy_rx_defines.svh"

module dphy_rx_props (
  input logic                        byte_clk_i,
  input logic                        rst_n_i,
  input logic                        eop_i,
  input logic                        valid_o,
  input logic                        beat_valid,
  input logic                        reset_align,
  input logic [`DPHY_DATA_LANES-1:0] hs_valid,
  input logic [`DPHY_DATA_LANES-1:0] lane_sot,
  input logic [`DPHY_DATA_LANES-1:0] nonempty
);

  // Lanes that already locked in the current packet
  logic [`DPHY_DATA_LANES-1:0] sot_seen;
  // Some lane left LP_STOP for HS since the last realignment
  logic                        hs_seen;

  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i || eop_i)
      sot_seen <= '0;
    else
      sot_seen <= sot_seen | lane_sot;
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i || reset_align)
      hs_seen <= 1'b0;
    else if (|hs_valid)
      hs_seen <= 1'b1;
  end

  // Words only come out of a packet that had HS traffic
  valid_needs_hs: assert property (@(posedge byte_clk_i) disable iff (!rst_n_i)
    valid_o |-> hs_seen)
    else $error("valid_o while all lanes stayed in LP_STOP");

  sot_once: assert property (@(posedge byte_clk_i) disable iff (!rst_n_i)
    !(|(lane_sot & sot_seen)))
    else $error("second lane_sot within one packet");

  realign_after_eop: assert property (@(posedge byte_clk_i) disable iff (!rst_n_i)
    eop_i |=> reset_align)
    else $error("reset_align missing after eop_i");

  realign_source: assert property (@(posedge byte_clk_i) disable iff (!rst_n_i)
    reset_align |-> $past(eop_i))
    else $error("reset_align without eop_i");

  beat_needs_data: assert property (@(posedge byte_clk_i) disable iff (!rst_n_i)
    beat_valid |-> $past(&nonempty))
    else $error("beat_valid while a lane buffer was empty");

endmodule

bind dphy_rx_core dphy_rx_props props (
  .byte_clk_i  ( byte_clk_i              ),
  .rst_n_i     ( rst_n_i                 ),
  .eop_i       ( eop_i                   ),
  .valid_o     ( valid_o                 ),
  .beat_valid  ( beat_valid              ),
  .reset_align ( lane_if.reset_align     ),
  .hs_valid    ( hs_valid                ),
  .lane_sot    ( lane_if.lane_sot        ),
  .nonempty    ( word_align.nonempty     )
);

// ==== hw/dphy_rx_core.sv ====
`timescale 1ns/1ps

`include "dphy_rx_defines.svh"

module dphy_rx_core import dphy_rx_pkg::*; (
  input  logic                            byte_clk_i,
  input  logic                            rst_n_i,
  input  logic                            enable_i,
  input  logic                            eop_i,
  input  logic [`DPHY_DATA_LANES-1:0]     lp_data_p_i,
  input  logic [`DPHY_DATA_LANES-1:0]     lp_data_n_i,
  input  logic [8*`DPHY_DATA_LANES-1:0]   raw_byte_i,
  output logic [31:0]                     data_o,
  output logic                            valid_o
);

  logic [`DPHY_DATA_LANES-1:0]       hs_valid;
  lane_byte_t [`DPHY_DATA_LANES-1:0] word_beat;
  logic                              beat_valid;

  dphy_lane_if lane_if ();

  generate
    for (genvar i = 0; i < `DPHY_DATA_LANES; i++)
    begin : data_lane
      dphy_settle_ignore settle_ignore (
        .byte_clk_i ( byte_clk_i     ),
        .rst_n_i    ( rst_n_i        ),
        .enable_i   ( enable_i       ),
        .lp_p_i     ( lp_data_p_i[i] ),
        .lp_n_i     ( lp_data_n_i[i] ),
        .hs_valid_o ( hs_valid[i]    )
      );

      dphy_byte_align #(
        .lane_idx   ( i                    )
      ) byte_align (
        .byte_clk_i ( byte_clk_i           ),
        .rst_n_i    ( rst_n_i              ),
        .hs_valid_i ( hs_valid[i]          ),
        .raw_byte_i ( raw_byte_i[i*8 +: 8] ),
        .lane_o     ( lane_if.byte_side    )
      );
    end
  endgenerate

  dphy_word_align word_align (
    .byte_clk_i   ( byte_clk_i        ),
    .rst_n_i      ( rst_n_i           ),
    .eop_i        ( eop_i             ),
    .lanes_i      ( lane_if.word_side ),
    .word_beat_o  ( word_beat         ),
    .beat_valid_o ( beat_valid        )
  );

  dphy_32b_map mapper (
    .byte_clk_i   ( byte_clk_i ),
    .rst_n_i      ( rst_n_i    ),
    .eop_i        ( eop_i      ),
    .word_beat_i  ( word_beat  ),
    .beat_valid_i ( beat_valid ),
    .data_o       ( data_o     ),
    .valid_o      ( valid_o    )
  );

endmodule

// ==== hw/dphy_32b_map.sv ====
`timescale 1ns/1ps

`include "dphy_rx_defines.svh"

module dphy_32b_map import dphy_rx_pkg::*; (
  input  logic                              byte_clk_i,
  input  logic                              rst_n_i,
  input  logic                              eop_i,
  input  lane_byte_t [`DPHY_DATA_LANES-1:0] word_beat_i,
  input  logic                              beat_valid_i,
  output logic [31:0]                       data_o,
  output logic                              valid_o
);

  logic [31:0] acc_q;
  logic [31:0] acc_next;
  logic [2:0]  fill_q;
  logic [2:0]  fill_next;

  // Lane 0 takes the lowest free byte
  always_comb
  begin
    acc_next  = acc_q;
    fill_next = fill_q;
    if (beat_valid_i)
    begin
      for (int l = 0; l < `DPHY_DATA_LANES; l++)
        acc_next[(int'(fill_q) + l) * 8 +: 8] = word_beat_i[l];
      fill_next = fill_q + 3'(`DPHY_DATA_LANES);
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i)
    begin
      acc_q   <= '0;
      fill_q  <= '0;
      valid_o <= 1'b0;
    end
    else
    begin
      valid_o <= 1'b0;
      if (fill_next == 3'd4 || (eop_i && fill_next != '0))
      begin
        // Unfilled bytes stay zero since acc is cleared after each word
        data_o  <= acc_next;
        valid_o <= 1'b1;
        acc_q   <= '0;
        fill_q  <= '0;
      end
      else
      begin
        acc_q  <= acc_next;
        fill_q <= fill_next;
      end
    end
  end

endmodule

// ==== hw/dphy_word_align.sv ====
`timescale 1ns/1ps

`include "dphy_rx_defines.svh"

module dphy_word_align import dphy_rx_pkg::*; (
  input  logic                              byte_clk_i,
  input  logic                              rst_n_i,
  input  logic                              eop_i,
  dphy_lane_if.word_side                    lanes_i,
  output lane_byte_t [`DPHY_DATA_LANES-1:0] word_beat_o,
  output logic                              beat_valid_o
);

  localparam int depth = `DPHY_DESKEW_DEPTH;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  lane_byte_t                fifo_mem [`DPHY_DATA_LANES][depth];
  logic [ptr_w-1:0]          wr_ptr   [`DPHY_DATA_LANES];
  logic [ptr_w-1:0]          rd_ptr   [`DPHY_DATA_LANES];
  logic [cnt_w-1:0]          fill_cnt [`DPHY_DATA_LANES];
  logic [`DPHY_DATA_LANES-1:0] nonempty;
  logic [`DPHY_DATA_LANES-1:0] push;
  logic                      pop;
  logic                      reset_align_q;

  // A beat leaves only once every lane has a byte waiting
  assign pop = (&nonempty) & ~eop_i;

  always_comb
  begin
    for (int l = 0; l < `DPHY_DATA_LANES; l++)
    begin
      nonempty[l] = (fill_cnt[l] != '0);
      push[l]     = lanes_i.lane_valid[l] & ((fill_cnt[l] != cnt_w'(depth)) | pop);
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    for (int l = 0; l < `DPHY_DATA_LANES; l++)
    begin
      if (push[l])
        fifo_mem[l][wr_ptr[l]] <= lanes_i.lane_byte[l];
      if (pop)
        word_beat_o[l] <= fifo_mem[l][rd_ptr[l]];
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i)
    begin
      beat_valid_o  <= 1'b0;
      reset_align_q <= 1'b0;
      for (int l = 0; l < `DPHY_DATA_LANES; l++)
      begin
        wr_ptr[l]   <= '0;
        rd_ptr[l]   <= '0;
        fill_cnt[l] <= '0;
      end
    end
    else
    begin
      beat_valid_o  <= pop;
      reset_align_q <= eop_i;
      for (int l = 0; l < `DPHY_DATA_LANES; l++)
      begin
        // Fresh lock or end of packet empties the lane
        if (eop_i || lanes_i.lane_sot[l])
        begin
          wr_ptr[l]   <= '0;
          rd_ptr[l]   <= '0;
          fill_cnt[l] <= '0;
        end
        else
        begin
          if (push[l])
            wr_ptr[l] <= (wr_ptr[l] == ptr_w'(depth - 1)) ? '0 : wr_ptr[l] + 1'b1;
          if (pop)
            rd_ptr[l] <= (rd_ptr[l] == ptr_w'(depth - 1)) ? '0 : rd_ptr[l] + 1'b1;
          if (push[l] && !pop)
            fill_cnt[l] <= fill_cnt[l] + 1'b1;
          else if (!push[l] && pop)
            fill_cnt[l] <= fill_cnt[l] - 1'b1;
        end
      end
    end
  end

  assign lanes_i.reset_align = reset_align_q;

endmodule

// ==== hw/dphy_byte_align.sv ====
`timescale 1ns/1ps

`include "dphy_rx_defines.svh"

module dphy_byte_align import dphy_rx_pkg::*; #(
  parameter int lane_idx = 0
)(
  input  logic                  byte_clk_i,
  input  logic                  rst_n_i,
  input  logic                  hs_valid_i,
  input  lane_byte_t            raw_byte_i,
  dphy_lane_if.byte_side        lane_o
);

  align_state_e state;
  lane_byte_t   raw_q;
  lane_byte_t   prev_q;
  lane_byte_t   byte_q;
  logic         raw_hs_q;
  logic         prev_hs_q;
  logic         win_hs;
  logic [2:0]   offset_q;
  logic [2:0]   found_off;
  logic         found;
  logic         valid_q;
  logic         sot_q;
  logic [15:0]  window;

  // Older byte in the low half, bits arrive LSB first
  assign window = {raw_q, prev_q};
  assign win_hs = raw_hs_q & prev_hs_q;

  // Lowest offset wins
  always_comb
  begin
    found     = 1'b0;
    found_off = '0;
    for (int o = 7; o >= 0; o--)
    begin
      if (window[o +: 8] == `DPHY_SYNC_BYTE)
      begin
        found     = 1'b1;
        found_off = 3'(o);
      end
    end
  end

  always_ff @(posedge byte_clk_i)
  begin
    raw_q  <= raw_byte_i;
    prev_q <= raw_q;
    byte_q <= window[offset_q +: 8];
  end

  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i)
    begin
      state     <= ALIGN_HUNT;
      offset_q  <= '0;
      valid_q   <= 1'b0;
      sot_q     <= 1'b0;
      raw_hs_q  <= 1'b0;
      prev_hs_q <= 1'b0;
    end
    else
    begin
      raw_hs_q  <= hs_valid_i;
      prev_hs_q <= raw_hs_q;
      valid_q   <= 1'b0;
      sot_q     <= 1'b0;
      if (!win_hs || lane_o.reset_align)
        state <= ALIGN_HUNT;
      else if (state == ALIGN_HUNT)
      begin
        if (found)
        begin
          state    <= ALIGN_LOCKED;
          offset_q <= found_off;
          sot_q    <= 1'b1;
        end
      end
      else
        valid_q <= 1'b1;
    end
  end

  assign lane_o.lane_byte[lane_idx]  = byte_q;
  assign lane_o.lane_valid[lane_idx] = valid_q;
  assign lane_o.lane_sot[lane_idx]   = sot_q;

endmodule

// ==== hw/dphy_settle_ignore.sv ====
`timescale 1ns/1ps

`include "dphy_rx_defines.svh"

module dphy_settle_ignore import dphy_rx_pkg::*; (
  input  logic byte_clk_i,
  input  logic rst_n_i,
  input  logic enable_i,
  input  logic lp_p_i,
  input  logic lp_n_i,
  output logic hs_valid_o
);

  localparam int cnt_w = $clog2(`DPHY_SETTLE_CYCLES + 1);

  lane_state_e      state;
  logic [cnt_w-1:0] settle_cnt;
  logic [1:0]       lp;

  assign lp         = {lp_p_i, lp_n_i};
  assign hs_valid_o = (state == LP_HS);

  always_ff @(posedge byte_clk_i)
  begin
    if (!rst_n_i || !enable_i)
    begin
      state      <= LP_STOP;
      settle_cnt <= '0;
    end
    else
    begin
      case (state)
        LP_STOP:
        begin
          if (lp == 2'b01)
            state <= LP_RQST;
        end
        LP_RQST:
        begin
          // HS request must go straight to bridge state
          if (lp == 2'b00)
          begin
            state      <= LP_SETTLE;
            settle_cnt <= '0;
          end
          else if (lp != 2'b01)
            state <= LP_STOP;
        end
        LP_SETTLE:
        begin
          if (lp != 2'b00)
            state <= LP_STOP;
          else if (settle_cnt == cnt_w'(`DPHY_SETTLE_CYCLES - 1))
            state <= LP_HS;
          else
            settle_cnt <= settle_cnt + 1'b1;
        end
        default:
        begin
          if (lp != 2'b00)
            state <= LP_STOP;
        end
      endcase
    end
  end

endmodule

// ==== hw/dphy_lane_if.sv ====
`timescale 1ns/1ps

`include "dphy_rx_defines.svh"

interface dphy_lane_if import dphy_rx_pkg::*; ();

  // Aligned bytes, one slot per lane
  lane_byte_t [`DPHY_DATA_LANES-1:0] lane_byte;
  logic       [`DPHY_DATA_LANES-1:0] lane_valid;
  // One pulse per lane when its sync byte is locked
  logic       [`DPHY_DATA_LANES-1:0] lane_sot;
  logic                              reset_align;

  modport byte_side (
    output lane_byte,
    output lane_valid,
    output lane_sot,
    input  reset_align
  );

  modport word_side (
    input  lane_byte,
    input  lane_valid,
    input  lane_sot,
    output reset_align
  );

endinterface

// ==== hw/dphy_rx_pkg.sv ====
package dphy_rx_pkg;

  // LP line state per data lane
  typedef enum logic [1:0] {
    LP_STOP,
    LP_RQST,
    LP_SETTLE,
    LP_HS
  } lane_state_e;

  // Sync search state of the byte aligner
  typedef enum logic {
    ALIGN_HUNT,
    ALIGN_LOCKED
  } align_state_e;

  typedef logic [7:0] lane_byte_t;

endpackage

// ==== hw/dphy_rx_defines.svh ====
`ifndef DPHY_RX_DEFINES_SVH
`define DPHY_RX_DEFINES_SVH

// Number of HS data lanes (1, 2 or 4)
`define DPHY_DATA_LANES 2

// HS leader sync pattern, received LSB first
`define DPHY_SYNC_BYTE 8'hB8

// Byte clocks ignored after LP00 is first seen
`define DPHY_SETTLE_CYCLES 4

// Per-lane deskew buffer depth, equals max lane skew in bytes
`define DPHY_DESKEW_DEPTH 4

`endif
